// File: dv/pipeline_checker.sv
////////////////////////////////////////////////////////////////////////////
// commit scoreboard for the pipeline, samples on the falling edge
// expected commits are pushed in intake order by the testbench model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pipeline_checker import pipe_pkg::*; (
    input logic          clk,
    input logic          rst,
    input logic          commit_en,
    input reg_idx_t      commit_idx,
    input xlen_t         commit_data,
    input error_status_e error_status
);

    // expected commits, oldest first
    reg_idx_t exp_idx [$];
    xlen_t    exp_data [$];

    int error_count   = 0;
    int checked_count = 0;

    task automatic push_expected(input reg_idx_t idx, input xlen_t data);
        exp_idx.push_back(idx);
        exp_data.push_back(data);
    endtask

    function automatic int pending_count();
        return exp_idx.size();
    endfunction

    // wrong value, one line each
    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH time=%0t signal=%s expected=0x%08h actual=0x%08h",
                     $time, name, exp, act);
        end
    endtask

    // any other failure, plain text
    task automatic report_failure(input string msg);
        error_count++;
        $display("ERROR time=%0t %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // commit compare

    always @(negedge clk) begin : compare
        reg_idx_t e_idx;
        xlen_t    e_data;
        if (!rst && commit_en) begin
            // nothing younger than a halt or illegal may write
            if (error_status != NO_ERROR)
                report_failure("commit seen after the pipeline stopped");
            if (exp_idx.size() == 0) begin
                report_failure("commit seen with no expected entry");
            end else begin
                e_idx  = exp_idx.pop_front();
                e_data = exp_data.pop_front();
                checked_count++;
                expect_equal("commit_idx", 32'(e_idx), 32'(commit_idx));
                expect_equal("commit_data", e_data, commit_data);
            end
        end
    end

endmodule

// File: dv/tb_pipeline.sv
////////////////////////////////////////////////////////////////////////////
// random rv32 subset programs against a sequential isa model
// regfile has no reset, so the model keeps its registers across resets
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_pipeline import isa_pkg::*, pipe_pkg::*; ();

    // instructions per test
    localparam int N_INIT  = 31;
    localparam int N_INDEP = 60;
    localparam int N_CHAIN = 60;
    localparam int N_ZERO  = 40;
    localparam int N_PROG  = 20;
    localparam int N_TOTAL = N_INIT + N_INDEP + N_CHAIN + N_ZERO + 2 * (N_PROG + 1);
    localparam int CYCLE_LIMIT = 40 * N_TOTAL + 200;

    logic          clk;
    logic          rst;
    logic          inst_valid;
    inst_t         inst;
    logic          fetch_stall;
    logic          commit_en;
    reg_idx_t      commit_idx;
    xlen_t         commit_data;
    error_status_e error_status;

    integer seed = 91129;
    xlen_t  mregs [REG_COUNT];
    int     cycles = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     errors_before = 0;
    logic   stall_seen;

    pipeline UUT (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .fetch_stall  (fetch_stall),
        .commit_en    (commit_en),
        .commit_idx   (commit_idx),
        .commit_data  (commit_data),
        .error_status (error_status)
    );

    pipeline_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .commit_en    (commit_en),
        .commit_idx   (commit_idx),
        .commit_data  (commit_data),
        .error_status (error_status)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // kinds 0-7 register ops, 8-11 immediate ops, 12 lui
    function automatic inst_t encode(input int kind, input int rd, input int rs1,
                                     input int rs2, input logic [19:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = 7'b0;
        case (kind)
            0, 8:    f3 = FUNCT3_ADD_SUB;
            1: begin
                f3 = FUNCT3_ADD_SUB;
                f7 = FUNCT7_ALT;
            end
            2, 9:    f3 = FUNCT3_AND;
            3, 10:   f3 = FUNCT3_OR;
            4, 11:   f3 = FUNCT3_XOR;
            5:       f3 = FUNCT3_SLT;
            6:       f3 = FUNCT3_SLL;
            default: f3 = FUNCT3_SRL;
        endcase
        if (kind < 8)
            return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP};
        else if (kind < 12)
            return {imm[11:0], 5'(rs1), f3, 5'(rd), OP_IMM};
        else
            return {imm, 5'(rd), LUI};
    endfunction

    // isa semantics of the kept subset
    function automatic xlen_t model_result(input int kind, input xlen_t a,
                                           input xlen_t b_reg, input logic [19:0] imm);
        xlen_t b;
        b = (kind < 8) ? b_reg : {{20{imm[11]}}, imm[11:0]};
        case (kind)
            0, 8:    return a + b;
            1:       return a - b;
            2, 9:    return a & b;
            3, 10:   return a | b;
            4, 11:   return a ^ b;
            5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6:       return a << b[4:0];
            7:       return a >> b[4:0];
            default: return {imm, 12'b0};
        endcase
    endfunction

    // hold the word until an edge with fetch_stall low takes it
    task automatic send_word(input inst_t w);
        logic taken;
        inst       = w;
        inst_valid = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !fetch_stall;
            if (fetch_stall)
                stall_seen = 1'b1;
            @(posedge clk);
            #2;
        end
    endtask

    // one instruction through the DUT and the model
    task automatic issue(input int kind, input int rd, input int rs1, input int rs2);
        logic [19:0] imm;
        xlen_t       res;
        imm = 20'($random(seed));
        // random gap on inst_valid
        if (rand_range(0, 3) == 0) begin
            inst_valid = 1'b0;
            @(posedge clk);
            #2;
        end
        send_word(encode(kind, rd, rs1, rs2, imm));
        res = model_result(kind, mregs[rs1], mregs[rs2], imm);
        // x0 writes never commit
        if (rd != 0) begin
            mregs[rd] = res;
            u_checker.push_expected(reg_idx_t'(rd), res);
        end
    endtask

    // wait for outstanding commits, bounded
    task automatic drain();
        int n;
        n = 0;
        inst_valid = 1'b0;
        while (u_checker.pending_count() != 0 && n < 200) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (u_checker.pending_count() != 0)
            u_checker.report_failure("expected commits still outstanding after drain");
    endtask

    task automatic do_reset();
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = INST_NOP;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        // state right after reset
        @(negedge clk);
        u_checker.expect_equal("commit_en", 32'd0, 32'(commit_en));
        u_checker.expect_equal("fetch_stall", 32'd0, 32'(fetch_stall));
        u_checker.expect_equal("error_status", 32'(NO_ERROR), 32'(error_status));
        u_checker.expect_equal("queue depth", 32'd0, 32'(u_checker.pending_count()));
        @(posedge clk);
        #2;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (u_checker.error_count == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
        errors_before = u_checker.error_count;
    endtask

    // random program, then a stopping word, then the no-commit window
    task automatic stop_test(input inst_t w, input error_status_e want, input string name);
        int n;
        for (n = 0; n < N_PROG; n++)
            issue(rand_range(0, 12), rand_range(1, 31), rand_range(0, 31), rand_range(0, 31));
        send_word(w);
        // younger write offered next, addi x1,x0,0x123
        inst = encode(8, 1, 0, 0, 20'h00123);
        n = 0;
        while (error_status != want && n < 100) begin
            @(negedge clk);
            n++;
        end
        u_checker.expect_equal("error_status", 32'(want), 32'(error_status));
        u_checker.expect_equal("queue depth", 32'd0, 32'(u_checker.pending_count()));
        // younger word stays offered, must never be taken
        repeat (10) begin
            @(negedge clk);
            if (!fetch_stall)
                u_checker.report_failure("fetch_stall dropped after the pipeline stopped");
        end
        @(posedge clk);
        #2;
        finish_test(name);
        do_reset();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin : main
        int    i;
        int    r;
        inst_t bad;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = INST_NOP;
        stall_seen = 1'b0;
        for (i = 0; i < REG_COUNT; i++)
            mregs[i] = '0;

        do_reset();
        finish_test("reset state");

        // load every register, then ops with rd kept apart from the sources
        for (i = 1; i <= N_INIT; i++)
            issue(8, i, 0, 0);
        for (i = 0; i < N_INDEP; i++)
            issue(rand_range(0, 12), 16 + (i % 16), rand_range(1, 15), rand_range(1, 15));
        drain();
        finish_test("independent ops");

        // same register as source and dest, back to back
        stall_seen = 1'b0;
        for (i = 0; i < N_CHAIN; i++) begin
            r = rand_range(1, 3);
            issue(rand_range(0, 12), r, r, rand_range(1, 3));
        end
        drain();
        if (!stall_seen)
            u_checker.report_failure("fetch_stall never rose during the dependent chain");
        finish_test("dependent chains");

        // x0 as dest and as source
        for (i = 0; i < N_ZERO; i++)
            issue(rand_range(0, 12),
                  rand_range(0, 1) ? 0 : rand_range(1, 31),
                  rand_range(0, 1) ? 0 : rand_range(1, 31),
                  rand_range(0, 1) ? 0 : rand_range(1, 31));
        drain();
        finish_test("x0 handling");

        stop_test(INST_WFI, HALTED_ON_WFI, "wfi halt");

        // load major opcode, outside the subset
        bad      = inst_t'($random(seed));
        bad[6:0] = 7'b0000011;
        stop_test(bad, ILLEGAL_INST, "illegal word");

        $display("summary: tests %0d, failed %0d, commits checked %0d, errors %0d",
                 tests_run, tests_failed, u_checker.checked_count, u_checker.error_count);
        if (u_checker.error_count == 0 && tests_failed == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: tb.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/pipe_ifs.sv
verilog/regfile.sv
verilog/scoreboard.sv
verilog/decode_stage.sv
verilog/ex_stage.sv
verilog/wb_stage.sv
verilog/pipeline.sv
dv/pipeline_checker.sv
dv/tb_pipeline.sv

// File: verilog/decode_stage.sv
////////////////////////////////////////////////////////////////////////////
// IF/ID register, decoder and ID/EX issue register
// halt or illegal stops intake until reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     inst_valid,
    input  inst_t    inst,
    output logic     fetch_stall,
    output reg_idx_t rd1_idx,
    output reg_idx_t rd2_idx,
    input  xlen_t    rd1_data,
    input  xlen_t    rd2_data,
    output logic     rs1_used,
    output logic     rs2_used,
    output logic     issue_en,
    output reg_idx_t issue_rd,
    input  logic     hazard,
    id_ex_if.issue   ex
);

    logic      ifid_valid;
    inst_t     ifid_inst;
    logic      stopped;
    logic      stop_now;
    opcode_e   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t  rd;
    xlen_t     imm_i;
    xlen_t     imm_u;
    alu_func_e dec_func;
    xlen_t     dec_opb;
    logic      dec_writes;
    logic      dec_halt;
    logic      dec_illegal;
    logic      use_rs1;
    logic      use_rs2;

    ////////////////////////////////////////////////////////////////////////////
    // IF/ID register

    always_ff @(posedge clk) begin
        if (rst) begin
            ifid_valid <= 1'b0;
            ifid_inst  <= INST_NOP;
        end else if (!fetch_stall) begin
            ifid_valid <= inst_valid;
            if (inst_valid)
                ifid_inst <= inst;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode

    // field split
    assign opcode = opcode_e'(ifid_inst[6:0]);
    assign funct3 = ifid_inst[14:12];
    assign funct7 = ifid_inst[31:25];
    assign rd     = ifid_inst[11:7];
    assign imm_i  = {{(XLEN-12){ifid_inst[31]}}, ifid_inst[31:20]};
    assign imm_u  = {ifid_inst[31:12], 12'b0};

    always_comb begin
        dec_func    = ALU_ADD;
        dec_opb     = imm_i;
        dec_writes  = 1'b1;
        dec_halt    = 1'b0;
        dec_illegal = 1'b0;
        use_rs1     = 1'b1;
        use_rs2     = 1'b0;
        case (opcode)
            OP: begin
                dec_opb = rd2_data;
                use_rs2 = 1'b1;
                case (funct3)
                    FUNCT3_ADD_SUB: dec_func = (funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
                    FUNCT3_SLL:     dec_func = ALU_SLL;
                    FUNCT3_SLT:     dec_func = ALU_SLT;
                    FUNCT3_XOR:     dec_func = ALU_XOR;
                    FUNCT3_SRL:     dec_func = ALU_SRL;
                    FUNCT3_OR:      dec_func = ALU_OR;
                    FUNCT3_AND:     dec_func = ALU_AND;
                    // sltu not in the subset
                    default:        dec_illegal = 1'b1;
                endcase
                // only sub carries the alternate funct7
                if (funct7 != 7'b0 && !(funct7 == FUNCT7_ALT && funct3 == FUNCT3_ADD_SUB))
                    dec_illegal = 1'b1;
            end
            OP_IMM: begin
                case (funct3)
                    FUNCT3_ADD_SUB: dec_func = ALU_ADD;
                    FUNCT3_XOR:     dec_func = ALU_XOR;
                    FUNCT3_OR:      dec_func = ALU_OR;
                    FUNCT3_AND:     dec_func = ALU_AND;
                    default:        dec_illegal = 1'b1;
                endcase
            end
            LUI: begin
                dec_func = ALU_PASSB;
                dec_opb  = imm_u;
                use_rs1  = 1'b0;
            end
            SYSTEM: begin
                // wfi exact match, anything else is rejected
                dec_halt    = (ifid_inst == INST_WFI);
                dec_illegal = (ifid_inst != INST_WFI);
            end
            default: dec_illegal = 1'b1;
        endcase
        // halt and illegal go down as non-writing entries
        if (dec_halt || dec_illegal) begin
            dec_writes = 1'b0;
            use_rs1    = 1'b0;
            use_rs2    = 1'b0;
        end
    end

    // operand read and scoreboard query
    assign rd1_idx  = ifid_inst[19:15];
    assign rd2_idx  = ifid_inst[24:20];
    assign rs1_used = ifid_valid & use_rs1;
    assign rs2_used = ifid_valid & use_rs2;
    assign issue_rd = (ifid_valid && dec_writes) ? rd : '0;

    // issue unless blocked, stall intake while full and blocked
    assign stop_now    = ifid_valid & (dec_halt | dec_illegal);
    assign issue_en    = ifid_valid & ~hazard & ~stopped;
    assign fetch_stall = stopped | stop_now | (ifid_valid & hazard);

    // sticky stop after a halt or illegal issues
    always_ff @(posedge clk) begin
        if (rst)
            stopped <= 1'b0;
        else if (issue_en && stop_now)
            stopped <= 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX register, bubble when not issuing

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.valid   <= 1'b0;
            ex.halt    <= 1'b0;
            ex.illegal <= 1'b0;
        end else begin
            ex.valid   <= issue_en;
            ex.halt    <= issue_en & dec_halt;
            ex.illegal <= issue_en & dec_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_en) begin
            ex.alu_func <= dec_func;
            ex.opa      <= rd1_data;
            ex.opb      <= dec_opb;
            ex.dest     <= issue_rd;
        end
    end

    // a blocked entry stays put in IF/ID, nothing gets past it
    a_no_issue_on_hazard: assert property (
        @(posedge clk) disable iff (rst)
        (ifid_valid && hazard) |=> (ifid_valid && $stable(ifid_inst))
    );

endmodule

// File: verilog/ex_stage.sv
////////////////////////////////////////////////////////////////////////////
// single-cycle alu into the EX/WB register, never stalls
// shifts use opb[4:0] only
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    id_ex_if.execute  id,
    ex_wb_if.produce  wb
);

    xlen_t      alu_out;
    logic [4:0] shamt;
    logic       less;

    assign shamt = id.opb[4:0];
    // signed compare for slt
    assign less  = $signed(id.opa) < $signed(id.opb);

    always_comb begin
        case (id.alu_func)
            ALU_ADD:   alu_out = id.opa + id.opb;
            ALU_SUB:   alu_out = id.opa - id.opb;
            ALU_AND:   alu_out = id.opa & id.opb;
            ALU_OR:    alu_out = id.opa | id.opb;
            ALU_XOR:   alu_out = id.opa ^ id.opb;
            ALU_SLT:   alu_out = {{(XLEN-1){1'b0}}, less};
            ALU_SLL:   alu_out = id.opa << shamt;
            ALU_SRL:   alu_out = id.opa >> shamt;
            // lui
            ALU_PASSB: alu_out = id.opb;
            default:   alu_out = '0;
        endcase
    end

    // EX/WB control
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid   <= 1'b0;
            wb.halt    <= 1'b0;
            wb.illegal <= 1'b0;
        end else begin
            wb.valid   <= id.valid;
            wb.halt    <= id.valid & id.halt;
            wb.illegal <= id.valid & id.illegal;
        end
    end

    // EX/WB payload
    always_ff @(posedge clk) begin
        wb.result <= alu_out;
        wb.dest   <= id.dest;
    end

endmodule

// File: verilog/isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// rv32i integer subset only: no compressed, csr, branch or memory forms
// wfi is the only system word the decoder accepts
////////////////////////////////////////////////////////////////////////////
package isa_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // alu operations seen by ex
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASSB
    } alu_func_e;

    // funct3, shared by OP and OP_IMM
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL     = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // funct7 of sub
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // fixed words
    localparam logic [31:0] INST_WFI = 32'h1050_0073;
    localparam logic [31:0] INST_NOP = 32'h0000_0013;

endpackage

// File: verilog/pipe_ifs.sv
////////////////////////////////////////////////////////////////////////////
// stage to stage bundles, no handshake: the consumer takes every cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

// decode to execute, the ID/EX register contents
interface id_ex_if import isa_pkg::*, pipe_pkg::*; ();
    logic      valid;
    alu_func_e alu_func;
    xlen_t     opa;
    xlen_t     opb;
    reg_idx_t  dest;
    // non-writing entries
    logic      halt;
    logic      illegal;

    modport issue   (output valid, alu_func, opa, opb, dest, halt, illegal);
    modport execute (input  valid, alu_func, opa, opb, dest, halt, illegal);
endinterface

// execute to writeback, the EX/WB register contents
interface ex_wb_if import pipe_pkg::*; ();
    logic     valid;
    xlen_t    result;
    reg_idx_t dest;
    logic     halt;
    logic     illegal;

    modport produce (output valid, result, dest, halt, illegal);
    modport consume (input  valid, result, dest, halt, illegal);
endinterface

// File: verilog/pipe_pkg.sv
////////////////////////////////////////////////////////////////////////////
// datapath widths and shared types for the rv32 pipeline
// single issue only, 32 architectural registers with x0 hardwired
////////////////////////////////////////////////////////////////////////////
package pipe_pkg;

    // data word width
    localparam int XLEN = 32;

    // architectural register count
    localparam int REG_COUNT = 32;

    // data word
    typedef logic [XLEN-1:0] xlen_t;

    // register index, 5 bits for 32 regs
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // sticky status reported at the top
    typedef enum logic [1:0] {
        NO_ERROR      = 2'd0,
        ILLEGAL_INST  = 2'd1,
        HALTED_ON_WFI = 2'd2
    } error_status_e;

endpackage

// File: verilog/pipeline.sv
////////////////////////////////////////////////////////////////////////////
// in-order rv32 integer pipeline, scoreboard stalls instead of forwarding
// inst and inst_valid must hold while fetch_stall is high
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pipeline import pipe_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          inst_valid,
    input  inst_t         inst,
    output logic          fetch_stall,
    output logic          commit_en,
    output reg_idx_t      commit_idx,
    output xlen_t         commit_data,
    output error_status_e error_status
);

    // regfile read side
    reg_idx_t rd1_idx;
    reg_idx_t rd2_idx;
    xlen_t    rd1_data;
    xlen_t    rd2_data;

    // scoreboard query and issue
    logic     rs1_used;
    logic     rs2_used;
    logic     issue_en;
    reg_idx_t issue_rd;
    logic     hazard;

    id_ex_if id_ex ();
    ex_wb_if ex_wb ();

    ////////////////////////////////////////////////////////////////////////////
    // state shared by decode and writeback

    // commit ports double as the regfile write port
    regfile u_regfile (
        .clk      (clk),
        .rd1_idx  (rd1_idx),
        .rd2_idx  (rd2_idx),
        .rd1_data (rd1_data),
        .rd2_data (rd2_data),
        .wr_en    (commit_en),
        .wr_idx   (commit_idx),
        .wr_data  (commit_data)
    );

    scoreboard u_scoreboard (
        .clk        (clk),
        .rst        (rst),
        .issue_en   (issue_en),
        .issue_rd   (issue_rd),
        .rs1_idx    (rd1_idx),
        .rs2_idx    (rd2_idx),
        .rs1_used   (rs1_used),
        .rs2_used   (rs2_used),
        .commit_en  (commit_en),
        .commit_idx (commit_idx),
        .hazard     (hazard)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stages

    decode_stage u_decode (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .fetch_stall (fetch_stall),
        .rd1_idx     (rd1_idx),
        .rd2_idx     (rd2_idx),
        .rd1_data    (rd1_data),
        .rd2_data    (rd2_data),
        .rs1_used    (rs1_used),
        .rs2_used    (rs2_used),
        .issue_en    (issue_en),
        .issue_rd    (issue_rd),
        .hazard      (hazard),
        .ex          (id_ex.issue)
    );

    ex_stage u_ex (
        .clk (clk),
        .rst (rst),
        .id  (id_ex.execute),
        .wb  (ex_wb.produce)
    );

    wb_stage u_wb (
        .clk          (clk),
        .rst          (rst),
        .ex           (ex_wb.consume),
        .wr_en        (commit_en),
        .wr_idx       (commit_idx),
        .wr_data      (commit_data),
        .error_status (error_status)
    );

endmodule

// File: verilog/regfile.sv
////////////////////////////////////////////////////////////////////////////
// 2 read, 1 write register file, x0 always reads zero
// same-cycle write is visible on the read ports
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module regfile import pipe_pkg::*; (
    input  logic     clk,
    input  reg_idx_t rd1_idx,
    input  reg_idx_t rd2_idx,
    output xlen_t    rd1_data,
    output xlen_t    rd2_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  xlen_t    wr_data
);

    xlen_t regs [REG_COUNT];

    // read port 1, x0 then bypass then array
    always_comb begin
        if (rd1_idx == '0)
            rd1_data = '0;
        else if (wr_en && wr_idx == rd1_idx)
            rd1_data = wr_data;
        else
            rd1_data = regs[rd1_idx];
    end

    // read port 2
    always_comb begin
        if (rd2_idx == '0)
            rd2_data = '0;
        else if (wr_en && wr_idx == rd2_idx)
            rd2_data = wr_data;
        else
            rd2_data = regs[rd2_idx];
    end

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wr_en && wr_idx != '0)
            regs[wr_idx] <= wr_data;
    end

endmodule

// File: verilog/scoreboard.sv
////////////////////////////////////////////////////////////////////////////
// one pending bit per register, no forwarding behind it
// a commit in the read cycle counts as done, the regfile bypasses it
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module scoreboard import pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue_en,
    input  reg_idx_t issue_rd,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  logic     rs1_used,
    input  logic     rs2_used,
    input  logic     commit_en,
    input  reg_idx_t commit_idx,
    output logic     hazard
);

    logic [REG_COUNT-1:0] pending;
    logic [REG_COUNT-1:0] clr_mask;
    logic [REG_COUNT-1:0] set_mask;
    logic [REG_COUNT-1:0] live;

    // commit clears, issue of a nonzero rd sets
    assign clr_mask = commit_en ? (REG_COUNT'(1) << commit_idx) : '0;
    assign set_mask = (issue_en && issue_rd != '0) ? (REG_COUNT'(1) << issue_rd) : '0;

    // still pending after this cycle's commit
    assign live = pending & ~clr_mask;

    // sources, plus the dest itself
    // one bit cannot track two writers of the same reg in flight
    assign hazard = (rs1_used & live[rs1_idx])
                  | (rs2_used & live[rs2_idx])
                  | live[issue_rd];

    always_ff @(posedge clk) begin
        if (rst)
            pending <= '0;
        else
            pending <= live | set_mask;
    end

    // every writeback was issued through here first
    a_commit_was_pending: assert property (
        @(posedge clk) disable iff (rst)
        commit_en |-> pending[commit_idx]
    );

endmodule

// File: verilog/wb_stage.sv
////////////////////////////////////////////////////////////////////////////
// commit is combinational from EX/WB, error status is sticky until reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb_stage import pipe_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    ex_wb_if.consume      ex,
    output logic          wr_en,
    output reg_idx_t      wr_idx,
    output xlen_t         wr_data,
    output error_status_e error_status
);

    // only real writers to a nonzero reg commit
    assign wr_en   = ex.valid & ~ex.halt & ~ex.illegal & (ex.dest != '0);
    assign wr_idx  = ex.dest;
    assign wr_data = ex.result;

    // illegal wins over halt
    always_ff @(posedge clk) begin
        if (rst)
            error_status <= NO_ERROR;
        else if (ex.valid && ex.illegal)
            error_status <= ILLEGAL_INST;
        else if (ex.valid && ex.halt && error_status == NO_ERROR)
            error_status <= HALTED_ON_WFI;
    end

    // once stopped, stays stopped with the same cause
    a_status_sticky: assert property (
        @(posedge clk) disable iff (rst)
        (error_status != NO_ERROR) |=> $stable(error_status)
    );

endmodule
